//--- hdl/adc_rx_pkg.sv
// shared widths, sample types, mode codes and format select for the adc receive path
package adc_rx_pkg;

  //////////////////////////////
  // widths

  // pins per adc lane
  localparam int unsigned lane_bits = 7;
  // even and odd words interleaved
  localparam int unsigned sample_bits = 2 * lane_bits;
  // packed lane word as seen downstream
  localparam int unsigned word_bits = 16;

  //////////////////////////////
  // data types

  // one even or odd word off the pins
  typedef logic [lane_bits-1:0] half_word_t;
  // bit 2j+1 from odd word bit j, bit 2j from even word bit j
  typedef logic [sample_bits-1:0] sample_t;
  // one formatted lane
  typedef logic [word_bits-1:0] lane_word_t;
  // lane a upper half, lane b lower half
  typedef logic [2*word_bits-1:0] pair_word_t;
  // raw mode register value
  typedef logic [15:0] mode_code_t;

  //////////////////////////////
  // mode register codes

  // 14 bit left aligned
  localparam mode_code_t mode_msb14 = 16'h0002;
  // 14 bit sign extended
  localparam mode_code_t mode_sign14 = 16'h0008;

  // decoded format, msb12 covers every other code
  typedef enum logic [1:0] {
    fmt_msb14,
    fmt_sign14,
    fmt_msb12
  } fmt_sel_t;

endpackage

//--- hdl/lane_word_if.sv
// registered even/odd words of both lanes, passed from capture to formatting
interface lane_word_if;

  // lane a words
  adc_rx_pkg::half_word_t a_even;
  adc_rx_pkg::half_word_t a_odd;

  // lane b words
  adc_rx_pkg::half_word_t b_even;
  adc_rx_pkg::half_word_t b_odd;

  // driven by the input registers
  modport capture (
    output a_even,
    output a_odd,
    output b_even,
    output b_odd
  );

  // read by the format stage
  modport format (
    input a_even,
    input a_odd,
    input b_even,
    input b_odd
  );

endinterface

//--- hdl/lane_capture.sv
// input stage, registers the even/odd lane words and the write switch on adc0_clk
module lane_capture (
  input  logic                   adc0_clk,
  input  logic                   sys_rst,
  // de-interleaved words from the double rate capture
  input  adc_rx_pkg::half_word_t data_a_even,
  input  adc_rx_pkg::half_word_t data_a_odd,
  input  adc_rx_pkg::half_word_t data_b_even,
  input  adc_rx_pkg::half_word_t data_b_odd,
  // write enable from the control block
  input  logic                   adc_switch,
  lane_word_if.capture           words,
  output logic                   wr_switch_q
);

  //////////////////////////////
  // input registers

  // words and switch taken on the same edge
  // so the enable stays aligned with its sample
  always_ff @(posedge adc0_clk or posedge sys_rst) begin
    if (sys_rst) begin
      words.a_even <= '0;
      words.a_odd  <= '0;
      words.b_even <= '0;
      words.b_odd  <= '0;
      wr_switch_q  <= 1'b0;
    end else begin
      // lane a
      words.a_even <= data_a_even;
      words.a_odd  <= data_a_odd;
      // lane b
      words.b_even <= data_b_even;
      words.b_odd  <= data_b_odd;
      // switch follows the sample
      wr_switch_q  <= adc_switch;
    end
  end

endmodule

//--- hdl/sample_formatter.sv
// interleaves each lane, packs it in the selected format and registers the a/b pair
module sample_formatter (
  input  logic                   adc0_clk,
  input  logic                   sys_rst,
  lane_word_if.format            words,
  // mode register, sampled as the pair is registered
  input  adc_rx_pkg::mode_code_t mif_adc_mode,
  input  logic                   wr_switch_q,
  output adc_rx_pkg::pair_word_t fifo_din,
  output logic                   fifo_wr
);

  //////////////////////////////
  // helpers

  // odd word on the odd bit positions, even word on the even ones
  function automatic adc_rx_pkg::sample_t interleave(
    input adc_rx_pkg::half_word_t even_w,
    input adc_rx_pkg::half_word_t odd_w
  );
    adc_rx_pkg::sample_t s;
    for (int j = 0; j < adc_rx_pkg::lane_bits; j++) begin
      s[2*j+1] = odd_w[j];
      s[2*j]   = even_w[j];
    end
    return s;
  endfunction

  // build one 16 bit lane word
  function automatic adc_rx_pkg::lane_word_t pack_lane(
    input adc_rx_pkg::sample_t  s,
    input adc_rx_pkg::fmt_sel_t sel
  );
    adc_rx_pkg::lane_word_t w;
    case (sel)
      // sample on top, two zero bits below
      adc_rx_pkg::fmt_msb14:  w = {s, 2'b00};
      // sign bit doubled above the sample
      adc_rx_pkg::fmt_sign14: w = {s[13], s[13], s};
      // s[12] and s[11] dropped, four zero bits below
      default:                w = {s[13], s[10:0], 4'b0000};
    endcase
    return w;
  endfunction

  //////////////////////////////
  // mode decode

  adc_rx_pkg::fmt_sel_t fmt_sel;
  adc_rx_pkg::sample_t  sample_a;
  adc_rx_pkg::sample_t  sample_b;

  always_comb begin
    case (mif_adc_mode)
      adc_rx_pkg::mode_msb14:  fmt_sel = adc_rx_pkg::fmt_msb14;
      adc_rx_pkg::mode_sign14: fmt_sel = adc_rx_pkg::fmt_sign14;
      // anything else falls to the reduced form
      default:                 fmt_sel = adc_rx_pkg::fmt_msb12;
    endcase
  end

  // interleave both lanes
  assign sample_a = interleave(words.a_even, words.a_odd);
  assign sample_b = interleave(words.b_even, words.b_odd);

  //////////////////////////////
  // output register

  always_ff @(posedge adc0_clk or posedge sys_rst) begin
    if (sys_rst) begin
      fifo_din <= '0;
      fifo_wr  <= 1'b0;
    end else begin
      // lane a upper half
      fifo_din <= {pack_lane(sample_a, fmt_sel), pack_lane(sample_b, fmt_sel)};
      // strobe travels with the word
      fifo_wr  <= wr_switch_q;
    end
  end

  // mode bus fully known whenever a switched sample gets packed
  // an X code would silently fall to the reduced form
  a_mode_known: assert property (
    @(posedge adc0_clk) disable iff (sys_rst)
    wr_switch_q |-> !$isunknown(mif_adc_mode)
  );

endmodule

//--- hdl/sample_fifo.sv
// single clock sample FIFO with soft reset, popped into the output registers when not empty
module sample_fifo #(
  parameter int unsigned fifo_depth_log2 = 9
) (
  input  logic                   adc0_clk,
  input  logic                   sys_rst,
  // soft reset, clears pointers at the next edge
  input  logic                   mif_adc_fifo_rst,
  input  adc_rx_pkg::pair_word_t fifo_din,
  input  logic                   fifo_wr,
  output adc_rx_pkg::lane_word_t data_a_out,
  output adc_rx_pkg::lane_word_t data_b_out,
  output logic                   data_valid
);

  localparam int unsigned depth = 1 << fifo_depth_log2;

  // extra top bit tells full from empty
  typedef logic [fifo_depth_log2:0] ptr_t;

  //////////////////////////////
  // storage and pointers

  adc_rx_pkg::pair_word_t mem [depth];
  adc_rx_pkg::pair_word_t head_word;

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  logic full;
  logic empty;
  logic do_write;
  logic do_read;

  // same index, wrap bits differ
  assign full  = (wr_ptr[fifo_depth_log2] != rd_ptr[fifo_depth_log2]) &&
                 (wr_ptr[fifo_depth_log2-1:0] == rd_ptr[fifo_depth_log2-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  // soft reset swallows traffic in its cycle
  assign do_write = fifo_wr && !full && !mif_adc_fifo_rst;
  // read at full rate whenever something is held
  assign do_read  = !empty && !mif_adc_fifo_rst;

  assign head_word = mem[rd_ptr[fifo_depth_log2-1:0]];

  // memory array, no reset
  always_ff @(posedge adc0_clk) begin
    if (do_write) begin
      mem[wr_ptr[fifo_depth_log2-1:0]] <= fifo_din;
    end
  end

  // pointer update
  always_ff @(posedge adc0_clk or posedge sys_rst) begin
    if (sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (mif_adc_fifo_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  //////////////////////////////
  // output registers

  // data holds between pops, valid marks a fresh word
  always_ff @(posedge adc0_clk or posedge sys_rst) begin
    if (sys_rst) begin
      data_a_out <= '0;
      data_b_out <= '0;
      data_valid <= 1'b0;
    end else begin
      data_valid <= do_read;
      if (do_read) begin
        // lane a sits in the upper half
        data_a_out <= head_word[2*adc_rx_pkg::word_bits-1:adc_rx_pkg::word_bits];
        data_b_out <= head_word[adc_rx_pkg::word_bits-1:0];
      end
    end
  end

  // formatter strobe never lands on a full FIFO
  a_no_write_full: assert property (
    @(posedge adc0_clk) disable iff (sys_rst)
    fifo_wr |-> !full
  );

  // pointers parked at zero for every cycle of a soft reset
  a_soft_rst_ptrs: assert property (
    @(posedge adc0_clk) disable iff (sys_rst)
    mif_adc_fifo_rst |=> (wr_ptr == '0) && (rd_ptr == '0)
  );

endmodule

//--- hdl/adc_receive.sv
// top level of the adc receive path, capture to format to FIFO on adc0_clk
module adc_receive #(
  // 2 ** fifo_depth_log2 entries
  parameter int unsigned fifo_depth_log2 = 9
) (
  input  logic                   adc0_clk,
  input  logic                   sys_rst,
  input  logic                   mif_adc_fifo_rst,
  input  adc_rx_pkg::mode_code_t mif_adc_mode,
  input  logic                   adc_switch,
  // lane a even/odd words
  input  adc_rx_pkg::half_word_t data_a_even,
  input  adc_rx_pkg::half_word_t data_a_odd,
  // lane b even/odd words
  input  adc_rx_pkg::half_word_t data_b_even,
  input  adc_rx_pkg::half_word_t data_b_odd,
  output adc_rx_pkg::lane_word_t data_a_out,
  output adc_rx_pkg::lane_word_t data_b_out,
  output logic                   data_valid
);

  //////////////////////////////
  // internal links

  lane_word_if words_if ();

  logic                   wr_switch_q;
  adc_rx_pkg::pair_word_t fifo_din;
  logic                   fifo_wr;

  //////////////////////////////
  // stages

  // input registers
  lane_capture lane_capture_inst (
    .adc0_clk    (adc0_clk),
    .sys_rst     (sys_rst),
    .data_a_even (data_a_even),
    .data_a_odd  (data_a_odd),
    .data_b_even (data_b_even),
    .data_b_odd  (data_b_odd),
    .adc_switch  (adc_switch),
    .words       (words_if.capture),
    .wr_switch_q (wr_switch_q)
  );

  // interleave and pack
  sample_formatter sample_formatter_inst (
    .adc0_clk     (adc0_clk),
    .sys_rst      (sys_rst),
    .words        (words_if.format),
    .mif_adc_mode (mif_adc_mode),
    .wr_switch_q  (wr_switch_q),
    .fifo_din     (fifo_din),
    .fifo_wr      (fifo_wr)
  );

  // buffer and output registers
  sample_fifo #(
    .fifo_depth_log2 (fifo_depth_log2)
  ) sample_fifo_inst (
    .adc0_clk         (adc0_clk),
    .sys_rst          (sys_rst),
    .mif_adc_fifo_rst (mif_adc_fifo_rst),
    .fifo_din         (fifo_din),
    .fifo_wr          (fifo_wr),
    .data_a_out       (data_a_out),
    .data_b_out       (data_b_out),
    .data_valid       (data_valid)
  );

endmodule

//--- tests/tb_format_model.svh
// reference model for the adc receive testbench, included inside the testbench top module
`ifndef tb_format_model_svh
`define tb_format_model_svh

//////////////////////////////
// expected traffic

// expected a/b pairs in arrival order
logic [31:0] expected_q [$];
// sampling edge count of each expected pair
int unsigned stamp_q [$];

// wrong output values
int unsigned value_errors = 0;
// protocol trouble, stray or missing words
int unsigned other_errors = 0;

//////////////////////////////
// format rules

// odd word bit j on sample bit 2j+1, even word bit j on bit 2j
function automatic logic [13:0] interleave_bits(
  input logic [6:0] even_w,
  input logic [6:0] odd_w
);
  logic [13:0] s;
  for (int i = 0; i < 14; i++) begin
    if (i % 2 == 1) begin
      s[i] = odd_w[i / 2];
    end else begin
      s[i] = even_w[i / 2];
    end
  end
  return s;
endfunction

// pack one lane as the mode register asks
function automatic logic [15:0] format_lane(
  input logic [15:0] mode,
  input logic [13:0] s
);
  logic [15:0]        w;
  logic signed [15:0] ext;
  w = 16'h0000;
  if (mode == 16'h0002) begin
    // left aligned, two zero lsbs
    w = {s, 2'b00};
  end else if (mode == 16'h0008) begin
    // signed widening does the extension
    ext = $signed(s);
    w   = ext;
  end else begin
    // reduced form, s[12] and s[11] are lost
    w[15]   = s[13];
    w[14:4] = s[10:0];
  end
  return w;
endfunction

// queue one expected pair for a switched sample
task automatic push_expected(
  input logic [15:0] mode,
  input logic [6:0]  a_even,
  input logic [6:0]  a_odd,
  input logic [6:0]  b_even,
  input logic [6:0]  b_odd,
  input int unsigned stamp
);
  logic [15:0] lane_a;
  logic [15:0] lane_b;
  lane_a = format_lane(mode, interleave_bits(a_even, a_odd));
  lane_b = format_lane(mode, interleave_bits(b_even, b_odd));
  expected_q.push_back({lane_a, lane_b});
  stamp_q.push_back(stamp);
endtask

// compare and report a mismatch
task automatic check_value(
  input string       name,
  input logic [31:0] expected,
  input logic [31:0] actual
);
  if (actual !== expected) begin
    $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    value_errors++;
  end
endtask

`endif

//--- tests/tb_adc_receive.sv
// testbench for adc_receive, random lane words in all formats checked against a queue model
module tb_adc_receive;

  localparam int unsigned reset_cycles   = 16;
  localparam int unsigned traffic_cycles = 200;
  localparam int unsigned drain_cycles   = 5;
  // reset, first idle, four traffic phases, fifo reset pulse and the last phase
  localparam int unsigned stim_cycles = reset_cycles + drain_cycles +
                                        4 * (traffic_cycles + drain_cycles) +
                                        1 + drain_cycles + traffic_cycles + drain_cycles;
  localparam int unsigned timeout_cycles = 2 * stim_cycles + 100;

  logic        adc0_clk;
  logic        sys_rst;
  logic        mif_adc_fifo_rst;
  logic [15:0] mif_adc_mode;
  logic        adc_switch;
  logic [6:0]  data_a_even;
  logic [6:0]  data_a_odd;
  logic [6:0]  data_b_even;
  logic [6:0]  data_b_odd;
  logic [15:0] data_a_out;
  logic [15:0] data_b_out;
  logic        data_valid;

  integer      seed = 32'hcee1;
  int unsigned cycle_count = 0;
  // outputs must stay zero until the first word shows up
  logic        seen_valid = 1'b0;

  `include "tb_format_model.svh"

  adc_receive adc_receive_inst (
    .adc0_clk         (adc0_clk),
    .sys_rst          (sys_rst),
    .mif_adc_fifo_rst (mif_adc_fifo_rst),
    .mif_adc_mode     (mif_adc_mode),
    .adc_switch       (adc_switch),
    .data_a_even      (data_a_even),
    .data_a_odd       (data_a_odd),
    .data_b_even      (data_b_even),
    .data_b_odd       (data_b_odd),
    .data_a_out       (data_a_out),
    .data_b_out       (data_b_out),
    .data_valid       (data_valid)
  );

  //////////////////////////////
  // clock and timeout

  initial begin
    adc0_clk = 1'b0;
    forever #20 adc0_clk = ~adc0_clk;
  end

  // rising edges counted here, read on falling edges
  initial begin
    while (cycle_count < timeout_cycles) begin
      @(posedge adc0_clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycle_count);
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    $display("Testbench failed");
    $finish;
  end

  //////////////////////////////
  // falling edge helpers

  // outputs are stable half a cycle after the rising edge
  task automatic observe_outputs();
    logic [31:0] exp_pair;
    int unsigned stamp;
    if (data_valid) begin
      seen_valid = 1'b1;
      if (expected_q.size() == 0) begin
        $display("data_valid high at %0t with no sample waiting", $time);
        other_errors++;
      end else begin
        exp_pair = expected_q.pop_front();
        stamp    = stamp_q.pop_front();
        check_value("data_a_out", exp_pair[31:16], data_a_out);
        check_value("data_b_out", exp_pair[15:0], data_b_out);
        // three edges from sampling to output
        check_value("latency", 32'd3, cycle_count - stamp);
      end
    end else if (!seen_valid) begin
      check_value("data_a_out", 32'd0, data_a_out);
      check_value("data_b_out", 32'd0, data_b_out);
    end
  endtask

  // new random words, switch held on or random
  task automatic drive_sample(input bit random_switch);
    logic [31:0] rnd;
    rnd = $random(seed);
    {data_a_even, data_a_odd, data_b_even, data_b_odd} = rnd[27:0];
    adc_switch = random_switch ? rnd[31] : 1'b1;
    // sampled at the next rising edge
    if (adc_switch) begin
      push_expected(mif_adc_mode, data_a_even, data_a_odd, data_b_even, data_b_odd,
                    cycle_count + 1);
    end
  endtask

  task automatic run_traffic(input logic [15:0] mode, input int unsigned n,
                             input bit random_switch);
    for (int unsigned i = 0; i < n; i++) begin
      @(negedge adc0_clk);
      observe_outputs();
      // switch has been low long enough here
      if (i == 0) begin
        mif_adc_mode = mode;
      end
      drive_sample(random_switch);
    end
  endtask

  // switch off, pipeline drains
  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(negedge adc0_clk);
      observe_outputs();
      adc_switch = 1'b0;
    end
  endtask

  //////////////////////////////
  // stimulus

  initial begin
    logic [15:0] odd_mode;
    sys_rst          = 1'b1;
    mif_adc_fifo_rst = 1'b0;
    mif_adc_mode     = 16'h0002;
    adc_switch       = 1'b0;
    data_a_even      = '0;
    data_a_odd       = '0;
    data_b_even      = '0;
    data_b_odd       = '0;
    // outputs checked at zero through reset
    repeat (reset_cycles) begin
      @(negedge adc0_clk);
      observe_outputs();
    end
    sys_rst = 1'b0;
    idle_cycles(drain_cycles);
    // left aligned, then sign extended
    run_traffic(16'h0002, traffic_cycles, 1'b0);
    idle_cycles(drain_cycles);
    run_traffic(16'h0008, traffic_cycles, 1'b0);
    idle_cycles(drain_cycles);
    // any other code gives the reduced form
    odd_mode = $random(seed);
    while (odd_mode == 16'h0002 || odd_mode == 16'h0008) begin
      odd_mode = $random(seed);
    end
    run_traffic(odd_mode, traffic_cycles, 1'b0);
    idle_cycles(drain_cycles);
    // gaps in the write switch
    run_traffic(16'h0002, traffic_cycles, 1'b1);
    idle_cycles(drain_cycles);
    // soft reset pulse while idle
    @(negedge adc0_clk);
    observe_outputs();
    mif_adc_fifo_rst = 1'b1;
    idle_cycles(drain_cycles);
    mif_adc_fifo_rst = 1'b0;
    run_traffic(16'h0008, traffic_cycles, 1'b1);
    idle_cycles(drain_cycles);
    if (expected_q.size() != 0) begin
      $display("%0d expected samples never reached the outputs", expected_q.size());
      other_errors++;
    end
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+tests
hdl/adc_rx_pkg.sv
hdl/lane_word_if.sv
hdl/lane_capture.sv
hdl/sample_formatter.sv
hdl/sample_fifo.sv
hdl/adc_receive.sv
tests/tb_adc_receive.sv

//--- Bender.yml
package:
  name: adc_receive

sources:
  - files:
      - hdl/adc_rx_pkg.sv
      - hdl/lane_word_if.sv
      - hdl/lane_capture.sv
      - hdl/sample_formatter.sv
      - hdl/sample_fifo.sv
      - hdl/adc_receive.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_adc_receive.sv
